// File: verif/soc_stim.txt
# W addr wdata wstrb exp_error | R addr exp_rdata exp_error | I exp_msip exp_mtip
# T reads mtime low twice | B addr wdata wstrb exp_rdata exp_error, issued back to back
R 00000000 00000297 0
R 00000020 80000000 0
R 00000028 deadbeef 0
R 0000003c cafef00d 0
W 80000000 11223344 f 0
R 80000000 11223344 0
W 800003fc 0badf00d f 0
R 800003fc 0badf00d 0
W 80000004 a5a5a5a5 f 0
W 80000004 0000beef 3 0
W 80000004 77000000 8 0
R 80000004 77a5beef 0
R 10000000 00000000 1
R 00000040 00000000 1
W 10000000 ffffffff f 1
R 80000400 00000000 1
I 0 0
W 02000000 00000001 1 0
I 1 0
R 02000000 00000001 0
W 02000000 00000000 1 0
I 0 0
W 02000004 00000000 f 0
W 02000008 00000000 f 0
I 0 1
W 02000008 ffffffff f 0
I 0 0
T
B 00000004 00000000 0 02028593 0
B 80000000 00000000 0 11223344 0
B 10000000 00000000 0 00000000 1
B 80000008 cafe0001 f 00000000 0
B 80000008 00000000 0 cafe0001 0
B 02000020 00000000 0 00000000 1
B 0000003c 00000000 0 cafef00d 0

// File: vlog.f
design/soc_pkg.sv
design/bus_decoder.sv
design/boot_rom.sv
design/data_ram.sv
design/timer_regs.sv
design/timer_core.sv
design/soc_fabric_top.sv
verif/tb_soc_fabric.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator from the project root, then search the log for the fail message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_soc_fabric -f vlog.f -o tb_soc_fabric &&
./obj_dir/tb_soc_fabric > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: verif/tb_soc_fabric.sv
`default_nettype none

module tb_soc_fabric;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ready_timeout = 20;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp_rdata;
    logic        exp_error;
  } burst_op_t;

  logic              clock;
  logic              reset;
  soc_pkg::mem_req_t request;
  soc_pkg::mem_rsp_t response;
  logic              msip;
  logic              mtip;

  int        error_count;
  int        checks_run;
  burst_op_t burst_q[$];

  soc_fabric_top i_dut (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .response (response),
    .msip     (msip),
    .mtip     (mtip)
  );

  always #4 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks_run++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic wait_cycles(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic error);
    int   cycles;
    logic got_ready;
    request.valid = 1'b1;
    request.instr = 1'b0;
    request.addr = addr;
    request.wdata = wdata;
    request.wstrb = wstrb;
    cycles = 0;
    got_ready = 1'b0;
    rdata = '0;
    error = 1'b0;
    while (!got_ready && cycles < ready_timeout) begin
      @(posedge clock);
      #1;
      got_ready = response.ready;
      request.valid = 1'b0;  // The strobe lasts a single cycle.
      cycles++;
    end
    if (got_ready) begin
      check_value("ready_latency", cycles, 32'd1);
      rdata = response.rdata;
      error = response.error;
    end else begin
      error_count++;
      $display("No response within %0d cycles for address 0x%08h", ready_timeout, addr);
    end
  endtask

  // Each response is checked in the cycle after its own request.
  task automatic run_burst();
    int        count;
    burst_op_t op;
    count = burst_q.size();
    for (int i = 0; i <= count; i++) begin
      if (i > 0) begin
        op = burst_q[i - 1];
        check_value("burst_ready", {31'b0, response.ready}, 32'd1);
        check_value("burst_error", {31'b0, response.error}, {31'b0, op.exp_error});
        check_value("burst_rdata", response.rdata, op.exp_rdata);
      end
      if (i < count) begin
        op = burst_q[i];
        request.valid = 1'b1;
        request.instr = 1'b0;
        request.addr = op.addr;
        request.wdata = op.wdata;
        request.wstrb = op.wstrb;
      end else begin
        request.valid = 1'b0;
      end
      wait_cycles(1);
    end
    burst_q.delete();
  endtask

  task automatic run_stim_file(input int fd);
    int             code;
    int             fields;
    logic [63:0]    op_token;
    logic [7:0]     op_char;
    logic [1023:0]  skip_buf;
    logic [31:0]    a, b, c, d, e;
    logic [31:0]    rdata;
    logic [31:0]    first_time;
    logic           error;
    code = $fscanf(fd, "%s", op_token);
    while (code == 1) begin
      op_char = op_token[7:0];
      if (op_char != "B" && burst_q.size() > 0) begin
        run_burst();
      end
      case (op_char)
        "#": fields = $fgets(skip_buf, fd);  // Column description line.
        "W": begin
          fields = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          if (fields != 4) begin
            error_count++;
            $display("Malformed write line in the stimulus file");
          end else begin
            bus_access(a, b, c[3:0], rdata, error);
            check_value("rdata", rdata, 32'h0);
            check_value("error", {31'b0, error}, {31'b0, d[0]});
          end
        end
        "R": begin
          fields = $fscanf(fd, "%h %h %h", a, b, c);
          if (fields != 3) begin
            error_count++;
            $display("Malformed read line in the stimulus file");
          end else begin
            bus_access(a, 32'h0, 4'b0000, rdata, error);
            check_value("rdata", rdata, b);
            check_value("error", {31'b0, error}, {31'b0, c[0]});
          end
        end
        "I": begin
          fields = $fscanf(fd, "%h %h", a, b);
          if (fields != 2) begin
            error_count++;
            $display("Malformed interrupt line in the stimulus file");
          end else begin
            wait_cycles(1);  // Levels follow a register write one cycle after ready.
            check_value("idle_ready", {31'b0, response.ready}, 32'h0);
            check_value("msip", {31'b0, msip}, {31'b0, a[0]});
            check_value("mtip", {31'b0, mtip}, {31'b0, b[0]});
          end
        end
        "T": begin
          a = soc_pkg::timer_base_addr + soc_pkg::timer_time_lo_offset;
          bus_access(a, 32'h0, 4'b0000, first_time, error);
          check_value("error", {31'b0, error}, 32'h0);
          bus_access(a, 32'h0, 4'b0000, rdata, error);
          check_value("error", {31'b0, error}, 32'h0);
          check_value("mtime_increasing", {31'b0, rdata > first_time}, 32'd1);
        end
        "B": begin
          fields = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
          if (fields != 5) begin
            error_count++;
            $display("Malformed burst line in the stimulus file");
          end else begin
            burst_q.push_back('{addr: a, wdata: b, wstrb: c[3:0], exp_rdata: d,
                                exp_error: e[0]});
          end
        end
        default: begin
          error_count++;
          $display("Unknown opcode %c in the stimulus file", op_char);
        end
      endcase
      code = $fscanf(fd, "%s", op_token);
    end
    if (burst_q.size() > 0) begin
      run_burst();
    end
  endtask

  initial begin
    int fd;
    clock = 1'b0;
    reset = 1'b1;
    request = '0;
    error_count = 0;
    checks_run = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    fd = $fopen("verif/soc_stim.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the stimulus file verif/soc_stim.txt");
    end else begin
      run_stim_file(fd);
      $fclose(fd);
    end
    $display("Checks run: %0d, errors: %0d", checks_run, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/soc_fabric_top.sv
`default_nettype none

module soc_fabric_top (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t request,
  output soc_pkg::mem_rsp_t response,
  output logic              msip,
  output logic              mtip
);

  soc_pkg::mem_req_t rom_req;
  soc_pkg::mem_req_t ram_req;
  soc_pkg::mem_req_t timer_req;
  soc_pkg::mem_rsp_t rom_rsp;
  soc_pkg::mem_rsp_t ram_rsp;
  soc_pkg::mem_rsp_t timer_rsp;
  logic [63:0]       mtime;
  logic [63:0]       mtimecmp;

  bus_decoder bus_decoder_inst (
    .clock     (clock),
    .reset     (reset),
    .request   (request),
    .response  (response),
    .rom_req   (rom_req),
    .ram_req   (ram_req),
    .timer_req (timer_req),
    .rom_rsp   (rom_rsp),
    .ram_rsp   (ram_rsp),
    .timer_rsp (timer_rsp)
  );

  boot_rom boot_rom_inst (
    .clock (clock),
    .reset (reset),
    .req   (rom_req),
    .rsp   (rom_rsp)
  );

  data_ram data_ram_inst (
    .clock (clock),
    .reset (reset),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  timer_regs timer_regs_inst (
    .clock    (clock),
    .reset    (reset),
    .req      (timer_req),
    .rsp      (timer_rsp),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .msip     (msip)
  );

  timer_core timer_core_inst (
    .clock    (clock),
    .reset    (reset),
    .mtimecmp (mtimecmp),
    .mtime    (mtime),
    .mtip     (mtip)
  );

endmodule

`default_nettype wire

// File: design/timer_core.sv
`default_nettype none

module timer_core (
  input  logic        clock,
  input  logic        reset,
  input  logic [63:0] mtimecmp,
  output logic [63:0] mtime,
  output logic        mtip
);

  logic [63:0] mtime_q;
  logic        mtip_q;
  logic        expired;

  // The compare uses the current count and mtip follows one clock later.
  assign expired = mtime_q >= mtimecmp;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtip_q <= 1'b0;
    end else begin
      mtip_q <= expired;
    end
  end

  assign mtime = mtime_q;
  assign mtip = mtip_q;

endmodule

`default_nettype wire

// File: design/timer_regs.sv
`default_nettype none

module timer_regs (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  input  logic [63:0]       mtime,
  output logic [63:0]       mtimecmp,
  output logic              msip
);

  logic        write_en;
  logic        msip_q;
  logic [63:0] mtimecmp_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] read_word;

  assign write_en = req.valid && (req.wstrb != 4'b0000);

  always_ff @(posedge clock) begin
    if (reset) begin
      msip_q <= 1'b0;
      mtimecmp_q <= '1;  // Far future so that no timer interrupt fires after reset.
    end else if (write_en) begin
      if (req.addr == soc_pkg::timer_msip_offset && req.wstrb[0]) begin
        msip_q <= req.wdata[0];
      end
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          case (req.addr)
            soc_pkg::timer_cmp_lo_offset: mtimecmp_q[8*i +: 8] <= req.wdata[8*i +: 8];
            soc_pkg::timer_cmp_hi_offset: mtimecmp_q[32 + 8*i +: 8] <= req.wdata[8*i +: 8];
            default: ;
          endcase
        end
      end
    end
  end

  always_comb begin
    case (req.addr)
      soc_pkg::timer_msip_offset:    read_word = {31'b0, msip_q};
      soc_pkg::timer_cmp_lo_offset:  read_word = mtimecmp_q[31:0];
      soc_pkg::timer_cmp_hi_offset:  read_word = mtimecmp_q[63:32];
      soc_pkg::timer_time_lo_offset: read_word = mtime[31:0];
      soc_pkg::timer_time_hi_offset: read_word = mtime[63:32];
      default:                       read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata_q <= write_en ? '0 : read_word;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req.valid;
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.error = 1'b0;
    rsp.rdata = ready_q ? rdata_q : '0;
  end

  assign mtimecmp = mtimecmp_q;
  assign msip = msip_q;

endmodule

`default_nettype wire

// File: design/data_ram.sv
`default_nettype none

module data_ram (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  logic [31:0]                          mem [soc_pkg::ram_words];
  logic                                 ready_q;
  logic [31:0]                          rdata_q;
  logic [$clog2(soc_pkg::ram_words)-1:0] word_index;

  assign word_index = req.addr[$clog2(soc_pkg::ram_words)+1:2];

  always_ff @(posedge clock) begin
    if (req.valid) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[word_index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // A read sees the word as it was before any write in the same cycle.
  always_ff @(posedge clock) begin
    if (req.valid) begin
      if (req.wstrb == 4'b0000) begin
        rdata_q <= mem[word_index];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req.valid;
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.error = 1'b0;
    rsp.rdata = ready_q ? rdata_q : '0;
  end

  // The decoder must have stripped the base and kept the offset in range.
  offset_in_range: assert property (
    @(posedge clock) disable iff (reset)
    req.valid |-> (req.addr < (soc_pkg::ram_top_addr - soc_pkg::ram_base_addr))
  );

endmodule

`default_nettype wire

// File: design/boot_rom.sv
`default_nettype none

module boot_rom (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  logic                                 ready_q;
  logic [31:0]                          rdata_q;
  logic [$clog2(soc_pkg::rom_words)-1:0] word_index;

  assign word_index = req.addr[$clog2(soc_pkg::rom_words)+1:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req.valid;  // Writes are dropped but still acknowledged.
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      if (req.wstrb == 4'b0000) begin
        rdata_q <= soc_pkg::rom_image[word_index];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.error = 1'b0;
    rsp.rdata = ready_q ? rdata_q : '0;
  end

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
`default_nettype none

module bus_decoder (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t request,
  output soc_pkg::mem_rsp_t response,
  output soc_pkg::mem_req_t rom_req,
  output soc_pkg::mem_req_t ram_req,
  output soc_pkg::mem_req_t timer_req,
  input  soc_pkg::mem_rsp_t rom_rsp,
  input  soc_pkg::mem_rsp_t ram_rsp,
  input  soc_pkg::mem_rsp_t timer_rsp
);

  logic              rom_hit;
  logic              ram_hit;
  logic              timer_hit;
  logic              map_error;
  logic              error_pending;
  logic [31:0]       base_addr;
  soc_pkg::mem_req_t local_req;

  always_comb begin
    rom_hit = (request.addr >= soc_pkg::rom_base_addr) &&
              (request.addr < soc_pkg::rom_top_addr);
    ram_hit = (request.addr >= soc_pkg::ram_base_addr) &&
              (request.addr < soc_pkg::ram_top_addr);
    timer_hit = (request.addr >= soc_pkg::timer_base_addr) &&
                (request.addr < soc_pkg::timer_top_addr);

    base_addr = '0;
    if (ram_hit) begin
      base_addr = soc_pkg::ram_base_addr;
    end else if (timer_hit) begin
      base_addr = soc_pkg::timer_base_addr;
    end else if (rom_hit) begin
      base_addr = soc_pkg::rom_base_addr;
    end

    // Targets only ever see the offset inside their own region.
    local_req = request;
    local_req.addr = request.addr - base_addr;

    rom_req = local_req;
    rom_req.valid = request.valid && rom_hit;
    ram_req = local_req;
    ram_req.valid = request.valid && ram_hit;
    timer_req = local_req;
    timer_req.valid = request.valid && timer_hit;

    map_error = request.valid && !(rom_hit || ram_hit || timer_hit);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      error_pending <= 1'b0;
    end else begin
      error_pending <= map_error;  // Answer unmapped accesses on the next clock.
    end
  end

  always_comb begin
    response = '0;
    if (rom_rsp.ready) begin
      response = rom_rsp;
    end else if (ram_rsp.ready) begin
      response = ram_rsp;
    end else if (timer_rsp.ready) begin
      response = timer_rsp;
    end else if (error_pending) begin
      response.ready = 1'b1;
      response.error = 1'b1;
    end
  end

  // The targets and the error path share one response slot.
  one_responder_check: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0({rom_rsp.ready, ram_rsp.ready, timer_rsp.ready, error_pending})
  );

  ready_latency_check: assert property (
    @(posedge clock) disable iff (reset)
    request.valid |=> response.ready
  );

endmodule

`default_nettype wire

// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  typedef struct packed {
    logic        valid;
    logic        instr;  // Set for an instruction fetch.
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // All zero means a read.
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } mem_rsp_t;

  // Each region top is exclusive.
  localparam logic [31:0] rom_base_addr   = 32'h0000_0000;
  localparam logic [31:0] rom_top_addr    = 32'h0000_0040;
  localparam logic [31:0] timer_base_addr = 32'h0200_0000;
  localparam logic [31:0] timer_top_addr  = 32'h0200_0020;
  localparam logic [31:0] ram_base_addr   = 32'h8000_0000;
  localparam logic [31:0] ram_top_addr    = 32'h8000_0400;

  localparam int rom_words = 16;
  localparam int ram_words = 256;

  // Boot code loads the entry point from word 8 and jumps to the data RAM.
  localparam logic [31:0] rom_image [rom_words] = '{
    32'h0000_0297,  // auipc t0, 0
    32'h0202_8593,  // addi a1, t0, 32
    32'hf140_2573,  // csrr a0, mhartid
    32'h0202_a283,  // lw t0, 32(t0)
    32'h0002_8067,  // jr t0
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    32'h8000_0000,  // Entry point.
    32'h0000_0000,
    32'hdead_beef,
    32'h1234_5678,
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_006f,  // Spin here if the jump returns.
    32'hcafe_f00d
  };

  localparam logic [31:0] timer_msip_offset    = 32'h0000_0000;
  localparam logic [31:0] timer_cmp_lo_offset  = 32'h0000_0004;
  localparam logic [31:0] timer_cmp_hi_offset  = 32'h0000_0008;
  localparam logic [31:0] timer_time_lo_offset = 32'h0000_0010;
  localparam logic [31:0] timer_time_hi_offset = 32'h0000_0014;

endpackage

`default_nettype wire
